//--- verilog/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	////////////////////////////////////////
	// Widths

	localparam int DDR_ADDR_LEN = 32;   // DDR word address
	localparam int DDR_DATA_LEN = 64;   // DDR word, four bias lanes
	localparam int BIAS_LEN     = 16;   // Stored bias lane
	localparam int BIAS_OUT_LEN = 20;   // Bias after shift
	localparam int SHIFT_LEN    = 3;    // Bias shift, 0 to 4
	localparam int BUF_ADDR_LEN = 6;    // Buffer start address field
	localparam int LEN_LEN      = 8;    // Words minus one
	localparam int INST_LEN     = 48;

	////////////////////////////////////////
	// Instruction word

	typedef enum logic [1:0] {
		op_nop,
		op_load_bias,
		op_load_weight,
		op_config
	} opcode_t;

	typedef struct packed {
		opcode_t                   opcode;
		logic [DDR_ADDR_LEN-1:0]   ddr_st_addr;
		logic [LEN_LEN-1:0]        len;
		logic [BUF_ADDR_LEN-1:0]   buf_st_addr;
	} load_inst_t;

	typedef struct packed {
		opcode_t                           opcode;
		logic [SHIFT_LEN-1:0]              bias_shift;
		logic [INST_LEN-2-SHIFT_LEN-1:0]   reserved;
	} conf_inst_t;

	// Same word, decoded by opcode
	typedef union packed {
		load_inst_t ld;
		conf_inst_t cf;
	} instr_t;

	////////////////////////////////////////
	// Internal command bundles

	typedef struct packed {
		logic [DDR_ADDR_LEN-1:0] ddr_st_addr;
		logic [LEN_LEN-1:0]      len;
	} ddr_cmd_t;

	typedef struct packed {
		logic [DDR_ADDR_LEN-1:0] ddr_st_addr;
		logic [LEN_LEN-1:0]      len;
		logic [BUF_ADDR_LEN-1:0] buf_st_addr;
	} fill_conf_t;

endpackage

`default_nettype wire

//--- verilog/weight_buffer.sv
`default_nettype none

module weight_buffer
	import cnn_pkg::*;
#(
	parameter int ADDR_LEN = 6
) (
	input  logic                    clk,

	input  logic                    wr_en,
	input  logic [ADDR_LEN-1:0]     wr_addr,
	input  logic [DDR_DATA_LEN-1:0] wr_data,

	input  logic [ADDR_LEN-1:0]     rd_addr,
	output logic [DDR_DATA_LEN-1:0] ker_out
);

	logic [DDR_DATA_LEN-1:0] mem [2**ADDR_LEN];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		ker_out <= mem[rd_addr];   // Old data on a same-address write
	end

endmodule

`default_nettype wire

//--- verilog/bias_buffer.sv
`default_nettype none

module bias_buffer
	import cnn_pkg::*;
#(
	parameter int ADDR_LEN = 5
) (
	input  logic                    clk,

	input  logic                    wr_en,
	input  logic [ADDR_LEN-1:0]     wr_addr,
	input  logic [DDR_DATA_LEN-1:0] wr_data,

	input  logic [ADDR_LEN+1:0]     rd_addr,   // Word address, then 2-bit lane
	input  logic [SHIFT_LEN-1:0]    bias_shift,
	output logic [BIAS_OUT_LEN-1:0] bias_out
);

	logic [DDR_DATA_LEN-1:0] mem [2**ADDR_LEN];
	logic [DDR_DATA_LEN-1:0] rd_word;
	logic [BIAS_LEN-1:0]     lane;
	logic [BIAS_OUT_LEN-1:0] lane_ext;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	////////////////////////////////////////
	// Lane select, sign extend, shift

	assign rd_word  = mem[rd_addr[ADDR_LEN+1:2]];
	assign lane     = rd_word[rd_addr[1:0]*BIAS_LEN +: BIAS_LEN];   // Lane 0 in low bits
	assign lane_ext = {{(BIAS_OUT_LEN-BIAS_LEN){lane[BIAS_LEN-1]}}, lane};

	// Upper bits drop off on large shifts
	always_ff @(posedge clk) begin
		bias_out <= lane_ext << bias_shift;
	end

endmodule

`default_nettype wire

//--- verilog/fill_control.sv
`default_nettype none

module fill_control
	import cnn_pkg::*;
#(
	parameter int ADDR_LEN = 6
) (
	input  logic                clk,
	input  logic                reset,

	input  logic                conf,
	input  fill_conf_t          cfg,

	output ddr_cmd_t            ddr_cmd,
	output logic                ddr_conf,
	input  logic                ddr_empty,
	output logic                ddr_req,

	output logic                wr_en,
	output logic [ADDR_LEN-1:0] wr_addr,
	output logic                idle
);

	fill_conf_t         cfg_q;
	logic [LEN_LEN-1:0] word_cnt;   // Words popped so far
	logic               last;
	logic               filling;

	////////////////////////////////////////
	// Command and stream side

	assign ddr_cmd.ddr_st_addr = cfg_q.ddr_st_addr;
	assign ddr_cmd.len         = cfg_q.len;

	// No pop in the command cycle
	assign filling = ~idle & ~ddr_conf;
	assign ddr_req = filling & ~ddr_empty;
	assign last    = (word_cnt == cfg_q.len);

	// Each popped word is written in the same cycle
	assign wr_en   = ddr_req;
	assign wr_addr = ADDR_LEN'(cfg_q.buf_st_addr) + ADDR_LEN'(word_cnt);   // Wraps at depth

	////////////////////////////////////////
	// Control

	always_ff @(posedge clk) begin
		if (reset) begin
			idle     <= 1'b1;
			ddr_conf <= 1'b0;
			word_cnt <= '0;
		end else begin
			ddr_conf <= conf;   // Command one cycle after conf

			if (conf) begin
				idle     <= 1'b0;
				word_cnt <= '0;
			end else if (ddr_req) begin
				word_cnt <= word_cnt + 1'b1;
				if (last)
					idle <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conf)
			cfg_q <= cfg;
	end

endmodule

`default_nettype wire

//--- verilog/load_sequencer.sv
`default_nettype none

module load_sequencer
	import cnn_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,

	input  instr_t               instruct,
	input  logic                 inst_empty,
	output logic                 inst_req,

	input  logic                 bias_idle,
	input  logic                 weight_idle,
	output fill_conf_t           fill_conf,
	output logic                 bias_conf,
	output logic                 weight_conf,

	input  ddr_cmd_t             bias_cmd,
	input  logic                 bias_ddr_conf,
	input  ddr_cmd_t             weight_cmd,
	input  logic                 weight_ddr_conf,
	input  logic                 bias_req,
	input  logic                 weight_req,
	output logic                 bias_empty,
	output logic                 weight_empty,

	input  logic                 ddr_empty,
	output ddr_cmd_t             ddr_cmd,
	output logic                 ddr_conf,
	output logic                 ddr_req,

	output logic [SHIFT_LEN-1:0] bias_shift,
	output logic                 busy
);

	opcode_t op;
	logic    is_load;
	logic    conf_now;        // A conf pulse is out this cycle
	logic    running;
	logic    switch_weight;   // Active controller, 1 for weights
	logic    target_idle;

	////////////////////////////////////////
	// Decode and pop

	assign op       = instruct.ld.opcode;
	assign is_load  = (op == op_load_bias) || (op == op_load_weight);
	assign conf_now = bias_conf | weight_conf;

	assign target_idle = switch_weight ? weight_idle : bias_idle;
	assign busy        = conf_now | (running & ~target_idle);
	assign inst_req    = ~inst_empty & ~busy;   // FWFT, word is valid now

	always_ff @(posedge clk) begin
		if (reset) begin
			bias_conf     <= 1'b0;
			weight_conf   <= 1'b0;
			running       <= 1'b0;
			switch_weight <= 1'b0;
			bias_shift    <= '0;
		end else begin
			bias_conf   <= inst_req && (op == op_load_bias);
			weight_conf <= inst_req && (op == op_load_weight);

			if (inst_req && is_load)
				switch_weight <= (op == op_load_weight);

			if (inst_req && (op == op_config))
				bias_shift <= instruct.cf.bias_shift;

			// Load counts from conf until the controller is idle again
			if (conf_now)
				running <= 1'b1;
			else if (target_idle)
				running <= 1'b0;
		end
	end

	// Shared by both controllers, only the conf pulses differ
	always_ff @(posedge clk) begin
		if (inst_req && is_load) begin
			fill_conf.ddr_st_addr <= instruct.ld.ddr_st_addr;
			fill_conf.len         <= instruct.ld.len;
			fill_conf.buf_st_addr <= instruct.ld.buf_st_addr;
		end
	end

	////////////////////////////////////////
	// DDR routing

	assign ddr_cmd  = switch_weight ? weight_cmd : bias_cmd;
	assign ddr_conf = switch_weight ? weight_ddr_conf : bias_ddr_conf;
	assign ddr_req  = switch_weight ? weight_req : bias_req;

	// Inactive side sees an empty stream
	assign bias_empty   = switch_weight ? 1'b1 : ddr_empty;
	assign weight_empty = switch_weight ? ddr_empty : 1'b1;

endmodule

`default_nettype wire

//--- verilog/cnn_load_top.sv
`default_nettype none

module cnn_load_top
	import cnn_pkg::*;
#(
	parameter int ADDR_LEN_BB = 5,
	parameter int ADDR_LEN_WB = 6
) (
	input  logic                    clk,
	input  logic                    reset,

	input  instr_t                  instruct,
	input  logic                    inst_empty,
	output logic                    inst_req,

	output ddr_cmd_t                ddr_cmd,
	output logic                    ddr_conf,
	input  logic                    ddr_empty,
	output logic                    ddr_req,
	input  logic [DDR_DATA_LEN-1:0] ddr_data,

	input  logic [ADDR_LEN_BB+1:0]  bias_rd_addr,
	output logic [BIAS_OUT_LEN-1:0] bias_out,
	input  logic [ADDR_LEN_WB-1:0]  wb_rd_addr,
	output logic [DDR_DATA_LEN-1:0] ker_out,

	output logic                    busy
);

	fill_conf_t fill_conf;
	logic       bias_conf;
	logic       weight_conf;
	logic       bias_idle;
	logic       weight_idle;

	// Per-controller DDR side
	ddr_cmd_t   bias_cmd;
	ddr_cmd_t   weight_cmd;
	logic       bias_ddr_conf;
	logic       weight_ddr_conf;
	logic       bias_req;
	logic       weight_req;
	logic       bias_empty;
	logic       weight_empty;

	logic [SHIFT_LEN-1:0]   bias_shift;
	logic                   bias_wr_en;
	logic [ADDR_LEN_BB-1:0] bias_wr_addr;
	logic                   weight_wr_en;
	logic [ADDR_LEN_WB-1:0] weight_wr_addr;

	////////////////////////////////////////
	// Control

	load_sequencer seq_i (
		.clk             (clk),
		.reset           (reset),
		.instruct        (instruct),
		.inst_empty      (inst_empty),
		.inst_req        (inst_req),
		.bias_idle       (bias_idle),
		.weight_idle     (weight_idle),
		.fill_conf       (fill_conf),
		.bias_conf       (bias_conf),
		.weight_conf     (weight_conf),
		.bias_cmd        (bias_cmd),
		.bias_ddr_conf   (bias_ddr_conf),
		.weight_cmd      (weight_cmd),
		.weight_ddr_conf (weight_ddr_conf),
		.bias_req        (bias_req),
		.weight_req      (weight_req),
		.bias_empty      (bias_empty),
		.weight_empty    (weight_empty),
		.ddr_empty       (ddr_empty),
		.ddr_cmd         (ddr_cmd),
		.ddr_conf        (ddr_conf),
		.ddr_req         (ddr_req),
		.bias_shift      (bias_shift),
		.busy            (busy)
	);

	fill_control #(.ADDR_LEN(ADDR_LEN_BB)) bias_fill (
		.clk       (clk),
		.reset     (reset),
		.conf      (bias_conf),
		.cfg       (fill_conf),
		.ddr_cmd   (bias_cmd),
		.ddr_conf  (bias_ddr_conf),
		.ddr_empty (bias_empty),
		.ddr_req   (bias_req),
		.wr_en     (bias_wr_en),
		.wr_addr   (bias_wr_addr),
		.idle      (bias_idle)
	);

	fill_control #(.ADDR_LEN(ADDR_LEN_WB)) weight_fill (
		.clk       (clk),
		.reset     (reset),
		.conf      (weight_conf),
		.cfg       (fill_conf),
		.ddr_cmd   (weight_cmd),
		.ddr_conf  (weight_ddr_conf),
		.ddr_empty (weight_empty),
		.ddr_req   (weight_req),
		.wr_en     (weight_wr_en),
		.wr_addr   (weight_wr_addr),
		.idle      (weight_idle)
	);

	////////////////////////////////////////
	// Buffers, write data straight from DDR

	bias_buffer #(.ADDR_LEN(ADDR_LEN_BB)) bias_buf_i (
		.clk        (clk),
		.wr_en      (bias_wr_en),
		.wr_addr    (bias_wr_addr),
		.wr_data    (ddr_data),
		.rd_addr    (bias_rd_addr),
		.bias_shift (bias_shift),
		.bias_out   (bias_out)
	);

	weight_buffer #(.ADDR_LEN(ADDR_LEN_WB)) weight_buf_i (
		.clk     (clk),
		.wr_en   (weight_wr_en),
		.wr_addr (weight_wr_addr),
		.wr_data (ddr_data),
		.rd_addr (wb_rd_addr),
		.ker_out (ker_out)
	);

endmodule

`default_nettype wire

//--- test/cnn_load_props.sv
`default_nettype none

module cnn_load_props (
	input logic clk,
	input logic reset,
	input logic start,       // inst_req or conf
	input logic busy,        // Load running or a controller active
	input logic ddr_conf,
	input logic ddr_req,
	input logic ddr_empty    // No word to take
);

	////////////////////////////////////////
	// Handshake rules

	start_while_free: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy) else $error("start while busy");

	req_only_with_data: assert property (@(posedge clk) disable iff (reset)
		ddr_req |-> !ddr_empty) else $error("ddr_req with no word to take");

	conf_single_pulse: assert property (@(posedge clk) disable iff (reset)
		ddr_conf |=> !ddr_conf) else $error("ddr_conf longer than one cycle");

	// Checked once reset has been seen for a full clock
	quiet_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !busy) else $error("busy during reset");

endmodule

bind load_sequencer cnn_load_props seq_props (.clk(clk), .reset(reset), .start(inst_req),
	.busy(busy | !bias_idle | !weight_idle), .ddr_conf(ddr_conf), .ddr_req(ddr_req),
	.ddr_empty(ddr_empty));

bind fill_control cnn_load_props fill_props (.clk(clk), .reset(reset), .start(conf),
	.busy(!idle), .ddr_conf(ddr_conf), .ddr_req(ddr_req),
	.ddr_empty(ddr_empty | (word_cnt > cfg_q.len)));

`default_nettype wire

//--- test/cnn_load_tb.sv
`default_nettype none

module cnn_load_tb
	import cnn_pkg::*;
();

	localparam int BB_LEN   = 5;
	localparam int WB_LEN   = 6;
	localparam int BIDX_LEN = BB_LEN + 2;   // Bias word address and lane
	localparam int BB_DEPTH = 2**BB_LEN;
	localparam int WB_DEPTH = 2**WB_LEN;

	logic                    clk = 1'b0;
	logic                    reset;
	instr_t                  instruct;
	logic                    inst_empty;
	logic                    inst_req;
	ddr_cmd_t                ddr_cmd;
	logic                    ddr_conf;
	logic                    ddr_empty;
	logic                    ddr_req;
	logic [DDR_DATA_LEN-1:0] ddr_data;
	logic [BIDX_LEN-1:0]     bias_rd_addr;
	logic [BIAS_OUT_LEN-1:0] bias_out;
	logic [WB_LEN-1:0]       wb_rd_addr;
	logic [DDR_DATA_LEN-1:0] ker_out;
	logic                    busy;

	////////////////////////////////////////
	// Stimulus and model state

	logic [31:0]          lfsr;
	logic [63:0]          ddr_mem [256];
	logic [63:0]          wb_model [WB_DEPTH];
	logic [WB_DEPTH-1:0]  wb_valid;
	logic [63:0]          bias_model [BB_DEPTH];
	logic [BB_DEPTH-1:0]  bias_valid;
	logic [SHIFT_LEN-1:0] shift_model;
	instr_t               iq [$];     // Instruction FIFO contents
	instr_t               pend [$];   // Popped loads, command not seen yet
	instr_t               cur;        // Load being streamed
	logic [31:0]          stream_addr;
	int                   stream_left;
	int                   pop_idx;
	logic                 rst_level;
	logic                 inst_gaps;
	logic                 ddr_gaps;
	logic                 prev_conf;
	logic [BIDX_LEN-1:0]  bias_rd_next;
	logic [WB_LEN-1:0]    wb_rd_next;
	int                   errors;
	int                   tests;
	int                   tests_failed;

	always #2 clk = ~clk;

	cnn_load_top #(.ADDR_LEN_BB(BB_LEN), .ADDR_LEN_WB(WB_LEN)) dut_i (.*);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[62:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic instr_t load_inst(input opcode_t op, input logic [LEN_LEN-1:0] len,
			input logic [BUF_ADDR_LEN-1:0] st);
		instr_t w;
		w.ld.opcode      = op;
		w.ld.ddr_st_addr = 32'(rand_bits(32));
		w.ld.len         = len;
		w.ld.buf_st_addr = st;
		return w;
	endfunction

	function automatic instr_t conf_inst(input logic [SHIFT_LEN-1:0] sh);
		instr_t w;
		w = 48'(rand_bits(48));   // Reserved bits left random
		w.cf.opcode     = op_config;
		w.cf.bias_shift = sh;
		return w;
	endfunction

	// Lane 0 sits in the low 16 bits of a word
	function automatic logic [BIAS_OUT_LEN-1:0] bias_expect(input logic [BIDX_LEN-1:0] idx);
		logic [15:0]        lane;
		logic signed [19:0] wide;
		lane = 16'(bias_model[idx[BIDX_LEN-1:2]] >> (16 * idx[1:0]));
		wide = 20'($signed(lane));
		return BIAS_OUT_LEN'(wide <<< shift_model);
	endfunction

	task automatic log_error(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	////////////////////////////////////////
	// One clock: drive, sample, update models

	task automatic run_cycle();
		instr_t              popped;
		logic [WB_LEN-1:0]   wa;
		logic [BB_LEN-1:0]   ba;
		@(negedge clk);
		reset      = rst_level;
		inst_empty = !(iq.size() > 0 && (!inst_gaps || rand_bits(1) != '0));
		if (iq.size() > 0)
			instruct = iq[0];
		ddr_empty    = !(stream_left > 0 && (!ddr_gaps || rand_bits(2) != '0));
		ddr_data     = ddr_empty ? rand_bits(64) : ddr_mem[stream_addr[7:0]];
		wb_rd_addr   = wb_rd_next;
		bias_rd_addr = bias_rd_next;
		#1;
		if (ddr_req === 1'b1 && ddr_empty)
			log_error("ddr_req was raised while ddr_empty was high");
		if (ddr_conf === 1'b1 && prev_conf === 1'b1)
			log_error("ddr_conf stayed high for two cycles");
		prev_conf = ddr_conf;
		if (inst_req === 1'b1) begin
			if (inst_empty)
				log_error("inst_req was raised while inst_empty was high");
			else begin
				popped = iq.pop_front();
				if (popped.ld.opcode == op_load_bias || popped.ld.opcode == op_load_weight)
					pend.push_back(popped);
				else if (popped.ld.opcode == op_config)
					shift_model = popped.cf.bias_shift;
			end
		end
		if (ddr_conf === 1'b1) begin
			if (pend.size() == 0)
				log_error("ddr_conf was pulsed with no load instruction pending");
			else begin
				cur = pend.pop_front();
				if (ddr_cmd.ddr_st_addr !== cur.ld.ddr_st_addr)
					log_error($sformatf("[FAIL] ddr_cmd.ddr_st_addr got %h expected %h",
						ddr_cmd.ddr_st_addr, cur.ld.ddr_st_addr));
				if (ddr_cmd.len !== cur.ld.len)
					log_error($sformatf("[FAIL] ddr_cmd.len got %h expected %h",
						ddr_cmd.len, cur.ld.len));
				stream_addr = cur.ld.ddr_st_addr;
				stream_left = int'(cur.ld.len) + 1;
				pop_idx     = 0;
			end
		end
		if (ddr_req === 1'b1 && !ddr_empty) begin
			wa = WB_LEN'(int'(cur.ld.buf_st_addr) + pop_idx);   // Start wraps at depth
			ba = BB_LEN'(int'(cur.ld.buf_st_addr) + pop_idx);
			if (cur.ld.opcode == op_load_weight) begin
				wb_model[wa] = ddr_data;
				wb_valid[wa] = 1'b1;
			end else begin
				bias_model[ba] = ddr_data;
				bias_valid[ba] = 1'b1;
			end
			pop_idx++;
			stream_addr++;
			stream_left--;
		end
	endtask

	function automatic logic work_left();
		return iq.size() != 0 || pend.size() != 0 || stream_left != 0 || busy !== 1'b0;
	endfunction

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		while (work_left() && n < limit) begin
			run_cycle();
			n++;
		end
		if (work_left())
			log_error($sformatf("Loads still running after %0d cycles", limit));
	endtask

	// Read address i while checking the word of address i-1
	task automatic check_weights();
		logic [WB_LEN-1:0] a;
		for (int i = 0; i <= WB_DEPTH; i++) begin
			wb_rd_next = WB_LEN'(i);
			run_cycle();
			a = WB_LEN'(i - 1);
			if (i > 0 && wb_valid[a] && ker_out !== wb_model[a])
				log_error($sformatf("[FAIL] ker_out at %h got %h expected %h",
					a, ker_out, wb_model[a]));
		end
	endtask

	task automatic check_bias();
		logic [BIDX_LEN-1:0] a;
		for (int i = 0; i <= 4 * BB_DEPTH; i++) begin
			bias_rd_next = BIDX_LEN'(i);
			run_cycle();
			a = BIDX_LEN'(i - 1);
			if (i > 0 && bias_valid[a[BIDX_LEN-1:2]] && bias_out !== bias_expect(a))
				log_error($sformatf("[FAIL] bias_out at %h shift %h got %h expected %h",
					a, shift_model, bias_out, bias_expect(a)));
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		if (errors != err_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - err_before);
		end else
			$display("test %s: passed", name);
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		int e;
		errors       = 0;
		tests        = 0;
		tests_failed = 0;
		lfsr         = 32'hd83;
		rst_level    = 1'b1;
		reset        = 1'b1;
		inst_empty   = 1'b1;
		instruct     = '0;
		ddr_empty    = 1'b1;
		ddr_data     = '0;
		bias_rd_addr = '0;
		wb_rd_addr   = '0;
		bias_rd_next = '0;
		wb_rd_next   = '0;
		stream_left  = 0;
		stream_addr  = '0;
		pop_idx      = 0;
		cur          = '0;
		prev_conf    = 1'b0;
		inst_gaps    = 1'b0;
		ddr_gaps     = 1'b0;
		shift_model  = '0;
		wb_valid     = '0;
		bias_valid   = '0;
		for (int i = 0; i < 256; i++)
			ddr_mem[8'(i)] = rand_bits(64);

		e = errors;
		for (int i = 0; i < 12; i++) begin
			if (i == 9)
				rst_level = 1'b0;   // Ten clocks in reset
			run_cycle();
			if (i > 0 && {inst_req, ddr_conf, ddr_req, busy} !== 4'h0)
				log_error($sformatf("[FAIL] {inst_req,ddr_conf,ddr_req,busy} got %h expected 0",
					{inst_req, ddr_conf, ddr_req, busy}));
		end
		end_test("reset", e);

		// Full fill first so every address has a known word
		e = errors;
		iq.push_back(load_inst(op_load_weight, 8'(WB_DEPTH - 1), '0));
		iq.push_back(load_inst(op_load_weight, 8'(rand_bits(4)), 6'(rand_bits(6))));
		wait_done(1000);
		check_weights();
		end_test("weight load", e);

		e = errors;
		iq.push_back(load_inst(op_load_bias, 8'(BB_DEPTH - 1), '0));
		wait_done(1000);
		for (int k = 0; k < 4; k++) begin
			iq.push_back(conf_inst(k == 3 ? 3'd4 : 3'(rand_bits(8) % 5)));
			wait_done(100);
			check_bias();
		end
		end_test("bias shift", e);

		e = errors;
		inst_gaps = 1'b1;
		ddr_gaps  = 1'b1;
		for (int k = 0; k < 3; k++) begin
			iq.push_back(load_inst(op_load_weight, 8'(rand_bits(6)), 6'(rand_bits(6))));
			iq.push_back(load_inst(op_load_bias, 8'(rand_bits(5)), 6'(rand_bits(6))));
		end
		wait_done(4000);
		check_weights();
		check_bias();
		end_test("back-pressure", e);

		// Nops must leave both buffers alone
		e = errors;
		iq.push_back(load_inst(op_nop, 8'(rand_bits(8)), 6'(rand_bits(6))));
		iq.push_back(load_inst(op_nop, 8'(rand_bits(8)), 6'(rand_bits(6))));
		wait_done(200);
		check_weights();
		check_bias();
		iq.push_back(load_inst(op_nop, 8'(rand_bits(8)), 6'(rand_bits(6))));
		iq.push_back(load_inst(op_load_weight, 8'(rand_bits(5)), 6'(rand_bits(6))));
		iq.push_back(load_inst(op_nop, 8'(rand_bits(8)), 6'(rand_bits(6))));
		wait_done(2000);
		check_weights();
		end_test("nop and gaps", e);

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/cnn_pkg.sv
verilog/weight_buffer.sv
verilog/bias_buffer.sv
verilog/fill_control.sv
verilog/load_sequencer.sv
verilog/cnn_load_top.sv
test/cnn_load_props.sv
test/cnn_load_tb.sv

//--- run.sh
#!/bin/bash
cd "$(dirname "$0")" \
	&& verilator --binary --assert -f build.f --top-module cnn_load_tb \
	&& ./obj_dir/Vcnn_load_tb | tee /dev/stderr | grep -qx "Done: no errors" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
